// ==== src/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// default fetch address after reset
	localparam word_t RESET_PC = 32'h0000_0000;

	////////////////////
	// opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// func3 values
	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;
	// lw and sw share the word size code
	localparam logic [2:0] F3_WORD   = 3'b010;
	localparam logic [2:0] F3_JALR   = 3'b000;

	////////////////////
	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// jal offset bits are scrambled in the word
	typedef struct packed {
		logic        imm20;
		logic [9:0]  imm10_1;
		logic        imm11;
		logic [7:0]  imm19_12;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} j_fmt_t;

	// one fetched word, five views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef enum logic [3:0] {
		OP_TYPE_R,
		OP_TYPE_I,
		OP_TYPE_LOAD,
		OP_TYPE_S,
		OP_TYPE_U,
		OP_TYPE_UPC,
		OP_TYPE_J,
		OP_TYPE_JR,
		OP_TYPE_ILLEGAL
	} op_type_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_AND,
		ALU_OR
	} alu_op_e;

endpackage

// ==== src/mem_bus_if.sv ====
`timescale 1ns/1ns

interface mem_bus_if;
	import rv_pkg::*;

	// request side, held stable until ack
	logic       req;
	logic       we;
	word_t      addr;
	word_t      wdata;
	logic [3:0] wmask;
	// response side, rdata valid with the ack pulse
	logic       ack;
	word_t      rdata;

	// requesting unit
	modport master (
		output req, we, addr, wdata, wmask,
		input  ack, rdata
	);

	// arbiter side
	modport slave (
		input  req, we, addr, wdata, wmask,
		output ack, rdata
	);

endinterface

// ==== src/ifu.sv ====
`timescale 1ns/1ns

module ifu #(
	parameter rv_pkg::word_t reset_pc = rv_pkg::RESET_PC
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          commit,
	input  rv_pkg::word_t dnpc,
	mem_bus_if.master     bus,
	output rv_pkg::inst_u inst,
	output rv_pkg::word_t inst_pc,
	output logic          inst_valid
);
	import rv_pkg::*;

	// architectural pc of the presented instruction
	word_t pc;
	word_t snpc;
	inst_u inst_q;
	// one-word prefetch of pc+4
	word_t pf_q;
	logic  pf_valid;
	// outstanding fetch
	logic  busy;
	word_t req_addr;
	// outstanding fetch belongs to an abandoned path
	logic  stale;

	// next state
	word_t pc_n;
	inst_u inst_n;
	word_t pf_n;
	word_t addr_n;
	logic  iv_n;
	logic  pfv_n;
	logic  busy_n;
	logic  stale_n;

	assign snpc = pc + 32'd4;

	always_comb begin
		pc_n    = pc;
		inst_n  = inst_q;
		pf_n    = pf_q;
		addr_n  = req_addr;
		iv_n    = inst_valid;
		pfv_n   = pf_valid;
		busy_n  = busy;
		stale_n = stale;

		////////////////////
		// response
		if (bus.ack) begin
			busy_n  = 1'b0;
			stale_n = 1'b0;
			// stale data just gets dropped
			if (!stale) begin
				if (!inst_valid) begin
					iv_n   = 1'b1;
					inst_n = inst_u'(bus.rdata);
				end else begin
					pfv_n = 1'b1;
					pf_n  = bus.rdata;
				end
			end
		end

		////////////////////
		// retire
		if (commit) begin
			pc_n = dnpc;
			if (dnpc == snpc && pfv_n) begin
				// buffered successor moves up
				iv_n   = 1'b1;
				inst_n = inst_u'(pf_n);
				pfv_n  = 1'b0;
			end else begin
				iv_n  = 1'b0;
				pfv_n = 1'b0;
				// in-flight fetch of pc+4 still serves a sequential step
				if (busy_n && dnpc != snpc) begin
					stale_n = 1'b1;
				end
			end
		end

		////////////////////
		// issue
		if (!busy_n) begin
			if (!iv_n) begin
				busy_n = 1'b1;
				addr_n = pc_n;
			end else if (!pfv_n) begin
				busy_n = 1'b1;
				addr_n = pc_n + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= reset_pc;
			inst_valid <= 1'b0;
			pf_valid   <= 1'b0;
			busy       <= 1'b0;
			stale      <= 1'b0;
		end else begin
			pc         <= pc_n;
			inst_valid <= iv_n;
			pf_valid   <= pfv_n;
			busy       <= busy_n;
			stale      <= stale_n;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		inst_q   <= inst_n;
		pf_q     <= pf_n;
		req_addr <= addr_n;
	end

	// read-only master
	assign bus.req   = busy;
	assign bus.we    = 1'b0;
	assign bus.addr  = req_addr;
	assign bus.wdata = '0;
	assign bus.wmask = 4'b0000;

	assign inst    = inst_q;
	assign inst_pc = pc;

endmodule

// ==== src/idu.sv ====
`timescale 1ns/1ns

module idu (
	input  rv_pkg::inst_u    inst,
	output rv_pkg::op_type_e op_type,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::word_t    imm,
	output rv_pkg::alu_op_e  alu_op
);
	import rv_pkg::*;

	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_u;
	word_t   imm_j;
	alu_op_e f3_alu;
	logic    f3_alu_ok;
	logic    r_funct7_ok;

	////////////////////
	// immediates per format, sign from bit 31
	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_u = {inst.u.imm, 12'b0};
	assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
		inst.j.imm11, inst.j.imm10_1, 1'b0};

	// alu function from func3
	always_comb begin
		f3_alu_ok = 1'b1;
		case (inst.r.funct3)
			F3_ADDSUB: f3_alu = ALU_ADD;
			F3_XOR:    f3_alu = ALU_XOR;
			F3_AND:    f3_alu = ALU_AND;
			F3_OR:     f3_alu = ALU_OR;
			default: begin
				f3_alu    = ALU_ADD;
				f3_alu_ok = 1'b0;
			end
		endcase
	end

	// only sub may set func7 bit 5
	assign r_funct7_ok = (inst.r.funct7 == 7'b0000000) ||
		(inst.r.funct7 == 7'b0100000 && inst.r.funct3 == F3_ADDSUB);

	////////////////////
	// type and immediate by opcode
	always_comb begin
		op_type = OP_TYPE_ILLEGAL;
		alu_op  = ALU_ADD;
		imm     = '0;
		// register fields sit at the same bits in every view
		rs1 = inst.r.rs1;
		rs2 = inst.r.rs2;
		rd  = inst.r.rd;
		case (inst.r.opcode)
			OPC_OP: begin
				if (f3_alu_ok && r_funct7_ok) begin
					op_type = OP_TYPE_R;
					alu_op  = inst.r.funct7[5] ? ALU_SUB : f3_alu;
				end
			end
			OPC_OP_IMM: begin
				if (f3_alu_ok) begin
					op_type = OP_TYPE_I;
					alu_op  = f3_alu;
					imm     = imm_i;
				end
			end
			OPC_LOAD: begin
				if (inst.i.funct3 == F3_WORD) begin
					op_type = OP_TYPE_LOAD;
					imm     = imm_i;
				end
			end
			OPC_STORE: begin
				if (inst.s.funct3 == F3_WORD) begin
					op_type = OP_TYPE_S;
					imm     = imm_s;
				end
			end
			OPC_LUI: begin
				op_type = OP_TYPE_U;
				imm     = imm_u;
			end
			OPC_AUIPC: begin
				op_type = OP_TYPE_UPC;
				imm     = imm_u;
			end
			OPC_JAL: begin
				op_type = OP_TYPE_J;
				imm     = imm_j;
			end
			OPC_JALR: begin
				if (inst.i.funct3 == F3_JALR) begin
					op_type = OP_TYPE_JR;
					imm     = imm_i;
				end
			end
			default: begin
				op_type = OP_TYPE_ILLEGAL;
			end
		endcase
	end

endmodule

// ==== src/exu.sv ====
`timescale 1ns/1ns

module exu (
	input  rv_pkg::op_type_e op_type,
	input  rv_pkg::alu_op_e  alu_op,
	input  rv_pkg::word_t    imm,
	input  rv_pkg::word_t    pc,
	input  rv_pkg::word_t    rdata1,
	input  rv_pkg::word_t    rdata2,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    load_data,
	output logic             wen,
	output rv_pkg::reg_idx_t waddr,
	output rv_pkg::word_t    wdata,
	output rv_pkg::word_t    mem_addr,
	output rv_pkg::word_t    dnpc
);
	import rv_pkg::*;

	word_t snpc;
	word_t ea;
	word_t alu_a;
	word_t alu_b;
	word_t alu_res;

	assign snpc = pc + 32'd4;
	// rs1 + imm, shared by load/store and jalr
	assign ea   = rdata1 + imm;

	////////////////////
	// alu operands
	always_comb begin
		case (op_type)
			OP_TYPE_R, OP_TYPE_I,
			OP_TYPE_LOAD, OP_TYPE_S: alu_a = rdata1;
			OP_TYPE_UPC:             alu_a = pc;
			// link value
			OP_TYPE_J, OP_TYPE_JR:   alu_a = snpc;
			// lui passes imm through
			default:                 alu_a = '0;
		endcase
	end

	always_comb begin
		case (op_type)
			OP_TYPE_R:               alu_b = rdata2;
			OP_TYPE_I, OP_TYPE_LOAD,
			OP_TYPE_S, OP_TYPE_U,
			OP_TYPE_UPC:             alu_b = imm;
			default:                 alu_b = '0;
		endcase
	end

	// alu
	always_comb begin
		case (alu_op)
			ALU_ADD: alu_res = alu_a + alu_b;
			ALU_SUB: alu_res = alu_a - alu_b;
			ALU_XOR: alu_res = alu_a ^ alu_b;
			ALU_AND: alu_res = alu_a & alu_b;
			ALU_OR:  alu_res = alu_a | alu_b;
			default: alu_res = alu_a + alu_b;
		endcase
	end

	////////////////////
	// register write
	// stores and unknown encodings write nothing
	assign wen      = (op_type != OP_TYPE_S) && (op_type != OP_TYPE_ILLEGAL);
	assign waddr    = rd;
	assign wdata    = (op_type == OP_TYPE_LOAD) ? load_data : alu_res;
	assign mem_addr = ea;

	////////////////////
	// next pc
	always_comb begin
		case (op_type)
			OP_TYPE_J:  dnpc = pc + imm;
			// jalr target with bit 0 cleared
			OP_TYPE_JR: dnpc = {ea[31:1], 1'b0};
			default:    dnpc = snpc;
		endcase
	end

endmodule

// ==== src/lsu.sv ====
`timescale 1ns/1ns

module lsu (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  rv_pkg::op_type_e op_type,
	input  rv_pkg::word_t    addr,
	input  rv_pkg::word_t    wdata,
	mem_bus_if.master        bus,
	output logic             done,
	output rv_pkg::word_t    load_data
);
	import rv_pkg::*;

	logic  is_mem;
	logic  issue;
	logic  busy;
	logic  we_q;
	word_t addr_q;
	word_t wdata_q;

	assign is_mem = (op_type == OP_TYPE_LOAD) || (op_type == OP_TYPE_S);
	// one request per instruction
	assign issue  = start && is_mem && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (busy && bus.ack) begin
			// req drops in the cycle after ack
			busy <= 1'b0;
		end else if (issue) begin
			busy <= 1'b1;
		end
	end

	// latched request
	always_ff @(posedge clk) begin
		if (issue) begin
			addr_q  <= addr;
			wdata_q <= wdata;
			we_q    <= (op_type == OP_TYPE_S);
		end
	end

	assign bus.req   = busy;
	assign bus.we    = we_q;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;
	// full word stores only
	assign bus.wmask = we_q ? 4'b1111 : 4'b0000;

	assign done      = busy && bus.ack;
	assign load_data = bus.rdata;

endmodule

// ==== src/gpr.sv ====
`timescale 1ns/1ns

module gpr (
	input  logic             clk,
	input  logic             rst,
	input  logic             wen,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::word_t    wdata,
	input  rv_pkg::reg_idx_t raddr1,
	input  rv_pkg::reg_idx_t raddr2,
	output rv_pkg::word_t    rdata1,
	output rv_pkg::word_t    rdata2
);
	import rv_pkg::*;

	word_t regs [32];

	// single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero
	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
	input  logic          clk,
	input  logic          rst,
	mem_bus_if.slave      lsu_bus,
	mem_bus_if.slave      ifu_bus,
	output logic          mem_req,
	output logic          mem_we,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output logic [3:0]    mem_wmask,
	input  logic          mem_ack,
	input  rv_pkg::word_t mem_rdata
);

	// grant held until the owner's ack
	logic locked;
	logic own_lsu;
	logic sel_lsu;

	// lsu wins when idle
	assign sel_lsu = locked ? own_lsu : lsu_bus.req;

	always_ff @(posedge clk) begin
		if (rst) begin
			locked  <= 1'b0;
			own_lsu <= 1'b0;
		end else if (locked) begin
			if (mem_ack) begin
				locked <= 1'b0;
			end
		end else if (lsu_bus.req || ifu_bus.req) begin
			locked  <= 1'b1;
			own_lsu <= lsu_bus.req;
		end
	end

	////////////////////
	// request mux
	assign mem_req   = sel_lsu ? lsu_bus.req   : ifu_bus.req;
	assign mem_we    = sel_lsu ? lsu_bus.we    : ifu_bus.we;
	assign mem_addr  = sel_lsu ? lsu_bus.addr  : ifu_bus.addr;
	assign mem_wdata = sel_lsu ? lsu_bus.wdata : ifu_bus.wdata;
	assign mem_wmask = sel_lsu ? lsu_bus.wmask : ifu_bus.wmask;

	// ack only to the owner
	assign lsu_bus.ack   = mem_ack && locked && own_lsu;
	assign ifu_bus.ack   = mem_ack && locked && !own_lsu;
	assign lsu_bus.rdata = mem_rdata;
	assign ifu_bus.rdata = mem_rdata;

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ns

module core_top #(
	parameter rv_pkg::word_t reset_pc = rv_pkg::RESET_PC
) (
	input  logic             clk,
	input  logic             rst,
	// external memory port
	output logic             mem_req,
	output logic             mem_we,
	output rv_pkg::word_t    mem_addr,
	output rv_pkg::word_t    mem_wdata,
	output logic [3:0]       mem_wmask,
	input  logic             mem_ack,
	input  rv_pkg::word_t    mem_rdata,
	// retire trace
	output logic             commit,
	output rv_pkg::word_t    commit_pc,
	output rv_pkg::reg_idx_t commit_rd,
	output logic             commit_wen,
	output rv_pkg::word_t    commit_wdata
);
	import rv_pkg::*;

	mem_bus_if ifu_bus ();
	mem_bus_if lsu_bus ();

	inst_u    inst;
	word_t    inst_pc;
	logic     inst_valid;
	op_type_e op_type;
	alu_op_e  alu_op;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;
	word_t    rdata1;
	word_t    rdata2;
	logic     wen;
	reg_idx_t waddr;
	word_t    wdata;
	word_t    ls_addr;
	word_t    dnpc;
	logic     lsu_done;
	word_t    load_data;
	logic     is_mem;

	////////////////////
	// commit
	assign is_mem = (op_type == OP_TYPE_LOAD) || (op_type == OP_TYPE_S);
	// memory ops retire on the lsu ack, the rest at once
	assign commit = inst_valid && (is_mem ? lsu_done : 1'b1);

	assign commit_pc    = inst_pc;
	assign commit_rd    = waddr;
	assign commit_wen   = wen;
	assign commit_wdata = wdata;

	ifu #(.reset_pc(reset_pc)) u_ifu (
		.clk(clk), .rst(rst), .commit(commit), .dnpc(dnpc), .bus(ifu_bus.master),
		.inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
	);

	idu u_idu (
		.inst(inst), .op_type(op_type), .rs1(rs1), .rs2(rs2), .rd(rd),
		.imm(imm), .alu_op(alu_op)
	);

	// register write only at commit
	gpr u_gpr (
		.clk(clk), .rst(rst), .wen(commit && wen), .waddr(waddr), .wdata(wdata),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2)
	);

	exu u_exu (
		.op_type(op_type), .alu_op(alu_op), .imm(imm), .pc(inst_pc),
		.rdata1(rdata1), .rdata2(rdata2), .rd(rd), .load_data(load_data),
		.wen(wen), .waddr(waddr), .wdata(wdata), .mem_addr(ls_addr), .dnpc(dnpc)
	);

	// store data comes straight from rs2
	lsu u_lsu (
		.clk(clk), .rst(rst), .start(inst_valid), .op_type(op_type), .addr(ls_addr),
		.wdata(rdata2), .bus(lsu_bus.master), .done(lsu_done), .load_data(load_data)
	);

	mem_arbiter u_arb (
		.clk(clk), .rst(rst), .lsu_bus(lsu_bus.slave), .ifu_bus(ifu_bus.slave),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

endmodule

// ==== sim/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

////////////////////
// instruction encoders

function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
	reg_idx_t rs1, reg_idx_t rs2);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
	reg_idx_t rs1, logic [11:0] imm);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
	return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_u(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
	return {imm, rd, opc};
endfunction

// byte offset, bit 0 is implied zero
function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// background pattern, every address bit matters
function automatic word_t fill_word(word_t addr);
	return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
endfunction

task automatic emit(word_t w);
	ref_mem[prog_len] = w;
	prog_len++;
endtask

////////////////////
// program builder

task automatic build_program();
	int n;
	int kind;
	int sel;
	int skip;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic [11:0] imm;
	logic [11:0] off;
	logic [2:0] f3;
	for (int a = 0; a < MEM_WORDS; a++) begin
		ref_mem[a] = fill_word(word_t'(a * 4));
	end
	prog_len = int'(RESET_PC[11:2]);
	// x31 = 0x800, base of the data region
	emit(enc_u(OPC_LUI, 5'd31, 20'h00001));
	emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd31, 5'd31, 12'h800));
	// alu, register and immediate forms
	emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd1, 5'd0, 12'h123));
	emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd2, 5'd0, -12'd5));
	emit(enc_r(7'h00, F3_ADDSUB, 5'd3, 5'd1, 5'd2));
	emit(enc_r(7'h20, F3_ADDSUB, 5'd4, 5'd1, 5'd2));
	emit(enc_r(7'h00, F3_XOR, 5'd5, 5'd1, 5'd2));
	emit(enc_r(7'h00, F3_AND, 5'd6, 5'd1, 5'd2));
	emit(enc_r(7'h00, F3_OR, 5'd7, 5'd1, 5'd2));
	emit(enc_i(OPC_OP_IMM, F3_XOR, 5'd8, 5'd1, 12'hFFF));
	emit(enc_i(OPC_OP_IMM, F3_AND, 5'd9, 5'd2, 12'h0F0));
	emit(enc_i(OPC_OP_IMM, F3_OR, 5'd10, 5'd1, 12'h700));
	// write to x0, then read it back
	emit(enc_r(7'h00, F3_ADDSUB, 5'd0, 5'd1, 5'd2));
	emit(enc_r(7'h00, F3_ADDSUB, 5'd11, 5'd0, 5'd1));
	emit(enc_u(OPC_LUI, 5'd12, 20'hABCDE));
	emit(enc_u(OPC_AUIPC, 5'd13, 20'h12345));
	// store then load back
	emit(enc_s(5'd4, 5'd31, 12'd8));
	emit(enc_i(OPC_LOAD, F3_WORD, 5'd14, 5'd31, 12'd8));
	emit(enc_s(5'd12, 5'd31, 12'd0));
	emit(enc_i(OPC_LOAD, F3_WORD, 5'd15, 5'd31, 12'd0));
	// jal skips one word
	emit(enc_j(5'd16, 21'd8));
	emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd17, 5'd0, 12'd99));
	// odd jalr offset, lands on auipc+12
	emit(enc_u(OPC_AUIPC, 5'd18, 20'h0));
	emit(enc_i(OPC_JALR, F3_JALR, 5'd19, 5'd18, 12'd13));
	emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd20, 5'd0, 12'd77));
	emit(enc_r(7'h00, F3_ADDSUB, 5'd21, 5'd16, 5'd19));

	// random block, x31 is never written
	n = 0;
	while (n < RAND_COUNT) begin
		kind = int'($urandom_range(9, 0));
		sel  = int'($urandom_range(4, 0));
		skip = int'($urandom_range(2, 0));
		rd   = reg_idx_t'($urandom_range(30, 0));
		rs1  = reg_idx_t'($urandom_range(31, 0));
		rs2  = reg_idx_t'($urandom_range(31, 0));
		imm  = 12'($urandom);
		off  = 12'($urandom_range(255, 0) * 4);
		// too close to the end for a jump
		if (kind == 9 && n > RAND_COUNT - 3) begin
			kind = 3;
		end
		case (sel)
			1:       f3 = F3_XOR;
			2:       f3 = F3_AND;
			3:       f3 = F3_OR;
			default: f3 = F3_ADDSUB;
		endcase
		if (kind <= 2) begin
			emit(enc_r((sel == 4) ? 7'h20 : 7'h00, f3, rd, rs1, rs2));
			n++;
		end else if (kind <= 4) begin
			emit(enc_i(OPC_OP_IMM, f3, rd, rs1, imm));
			n++;
		end else if (kind <= 6) begin
			emit(enc_i(OPC_LOAD, F3_WORD, rd, 5'd31, off));
			n++;
		end else if (kind <= 8) begin
			emit(enc_s(rs2, 5'd31, off));
			n++;
		end else if (sel < 2) begin
			// forward jal over one to three words
			emit(enc_j(rd, 21'(8 + 4 * skip)));
			// skipped words, only ever prefetched
			for (int k = 0; k <= skip; k++) begin
				emit(enc_r(7'h00, F3_XOR, rd, rs1, rs2));
			end
			n++;
		end else begin
			// auipc/jalr pair, odd offsets too
			emit(enc_u(OPC_AUIPC, 5'd30, 20'h0));
			emit(enc_i(OPC_JALR, F3_JALR, rd, 5'd30,
				12'(8 + 4 * skip + int'($urandom_range(1, 0)))));
			// target never splits a later pair
			for (int k = 0; k < skip; k++) begin
				emit(enc_r(7'h00, F3_XOR, rd, rs1, rs2));
			end
			n += 2;
		end
	end
	// landing pad for late jumps
	for (int k = 0; k < 3; k++) begin
		emit(enc_i(OPC_OP_IMM, F3_ADDSUB, 5'd0, 5'd0, 12'd0));
	end
	prog_end = word_t'(prog_len) << 2;
	// spin here once the run is over
	emit(enc_j(5'd0, 21'd0));
endtask

////////////////////
// reference model

function automatic word_t ref_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
	case (f3)
		3'b000:  return sub ? (a - b) : (a + b);
		3'b100:  return a ^ b;
		3'b110:  return a | b;
		3'b111:  return a & b;
		default: return '0;
	endcase
endfunction

// one instruction at ref_pc, updates regs, memory and pc
function automatic void ref_step(output word_t pc, output reg_idx_t rd, output logic wen,
	output word_t wdata, output logic st, output word_t st_addr, output word_t st_data);
	word_t ins;
	word_t a;
	word_t b;
	word_t imm_i;
	word_t imm_s;
	word_t imm_u;
	word_t imm_j;
	word_t ea_i;
	word_t ea_s;
	word_t nxt;
	ins   = ref_mem[ref_pc[11:2]];
	rd    = ins[11:7];
	a     = ref_regs[ins[19:15]];
	b     = ref_regs[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	imm_u = {ins[31:12], 12'b0};
	imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	ea_i  = a + imm_i;
	ea_s  = a + imm_s;
	pc      = ref_pc;
	nxt     = ref_pc + 32'd4;
	wen     = 1'b1;
	wdata   = '0;
	st      = 1'b0;
	st_addr = '0;
	st_data = '0;
	case (ins[6:0])
		7'b0110011: wdata = ref_alu(ins[14:12], ins[30], a, b);
		7'b0010011: wdata = ref_alu(ins[14:12], 1'b0, a, imm_i);
		7'b0000011: wdata = ref_mem[ea_i[11:2]];
		7'b0100011: begin
			wen     = 1'b0;
			st      = 1'b1;
			st_addr = ea_s;
			st_data = b;
			ref_mem[ea_s[11:2]] = b;
		end
		7'b0110111: wdata = imm_u;
		7'b0010111: wdata = ref_pc + imm_u;
		7'b1101111: begin
			wdata = ref_pc + 32'd4;
			nxt   = ref_pc + imm_j;
		end
		7'b1100111: begin
			wdata = ref_pc + 32'd4;
			nxt   = ea_i & ~32'd1;
		end
		default: wen = 1'b0;
	endcase
	if (wen && rd != 5'd0) begin
		ref_regs[rd] = wdata;
	end
	ref_pc = nxt;
endfunction

`endif

// ==== sim/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
	import rv_pkg::*;

	localparam int MEM_WORDS      = 1024;
	localparam int RAND_COUNT     = 200;
	localparam int COMMIT_TIMEOUT = 200;
	localparam int DELAY_SLOTS    = 256;

	logic       clk;
	logic       rst;
	logic       mem_req;
	logic       mem_we;
	word_t      mem_addr;
	word_t      mem_wdata;
	logic [3:0] mem_wmask;
	logic       mem_ack;
	word_t      mem_rdata;
	logic       commit;
	word_t      commit_pc;
	reg_idx_t   commit_rd;
	logic       commit_wen;
	word_t      commit_wdata;

	// memory model state
	word_t       mem [MEM_WORDS];
	int unsigned ack_delay [DELAY_SLOTS];
	int          delay_pos;
	logic        pending;
	int          wait_left;
	word_t       held_addr;
	logic        first_req;
	int          idx;
	// port writes, drained at each commit
	word_t       wr_addr_q [$];
	word_t       wr_data_q [$];

	// reference state
	word_t ref_mem [MEM_WORDS];
	word_t ref_regs [32];
	word_t ref_pc;
	int    prog_len;
	word_t prog_end;

	`include "tb_ref.svh"

	core_top #(.reset_pc(RESET_PC)) dut0 (
		.clk(clk), .rst(rst),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.commit(commit), .commit_pc(commit_pc), .commit_rd(commit_rd),
		.commit_wen(commit_wen), .commit_wdata(commit_wdata)
	);

	always #20 clk = ~clk;

	////////////////////
	// error reporting

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(string msg);
		$display("FAIL %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic report_problem(string msg);
		$display("%0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_commit(word_t got_pc, reg_idx_t got_rd, logic got_wen,
		word_t got_wdata, word_t exp_pc, reg_idx_t exp_rd, logic exp_wen, word_t exp_wdata);
		if (got_pc !== exp_pc) begin
			report_mismatch($sformatf("commit pc %h, expected %h", got_pc, exp_pc));
		end
		if (got_wen !== exp_wen) begin
			report_mismatch($sformatf("pc %h wen %b, expected %b", exp_pc, got_wen, exp_wen));
		end
		// rd and data only mean something with a write
		if (exp_wen && (got_rd !== exp_rd || got_wdata !== exp_wdata)) begin
			report_mismatch($sformatf("pc %h wrote x%0d=%h, expected x%0d=%h",
				exp_pc, got_rd, got_wdata, exp_rd, exp_wdata));
		end
	endtask

	task automatic check_store(word_t got_addr, word_t got_data, word_t exp_addr,
		word_t exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			report_mismatch($sformatf("store [%h]=%h, expected [%h]=%h",
				got_addr, got_data, exp_addr, exp_data));
		end
	endtask

	task automatic check_addr(word_t got, word_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("request address %h, expected %h", got, exp));
		end
	endtask

	// next commit, sampled mid-cycle
	task automatic wait_for_commit();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (commit !== 1'b1) begin
			cycles++;
			if (cycles > COMMIT_TIMEOUT) begin
				report_problem($sformatf("no commit for %0d cycles", COMMIT_TIMEOUT));
			end
			@(negedge clk);
		end
	endtask

	task automatic serve_request();
		if (mem_addr[31:12] != 20'd0 || mem_addr[1:0] != 2'd0) begin
			report_problem($sformatf("request to %h is outside the memory", mem_addr));
		end
		idx = int'(mem_addr[11:2]);
		if (mem_we) begin
			if (mem_wmask != 4'b1111) begin
				report_mismatch($sformatf("store mask %b, expected 1111", mem_wmask));
			end
			for (int b = 0; b < 4; b++) begin
				if (mem_wmask[b]) begin
					mem[idx][8*b +: 8] = mem_wdata[8*b +: 8];
				end
			end
			wr_addr_q.push_back(mem_addr);
			wr_data_q.push_back(mem_wdata);
		end
		mem_rdata = mem[idx];
	endtask

	////////////////////
	// memory model, random ack delay per request
	always begin
		@(posedge clk);
		#2;
		if (rst) begin
			mem_ack = 1'b0;
			pending = 1'b0;
		end else begin
			// ack lasts one cycle
			mem_ack = 1'b0;
			if (pending) begin
				if (mem_addr !== held_addr) begin
					report_problem("memory address changed before the ack");
				end
				wait_left--;
				if (wait_left == 0) begin
					serve_request();
					mem_ack = 1'b1;
					pending = 1'b0;
				end
			end else if (mem_req === 1'b1) begin
				if (first_req) begin
					check_addr(mem_addr, RESET_PC);
					first_req = 1'b0;
				end
				pending   = 1'b1;
				held_addr = mem_addr;
				wait_left = int'(ack_delay[delay_pos]);
				delay_pos = (delay_pos + 1) % DELAY_SLOTS;
			end
		end
	end

	////////////////////
	// stimulus and compare
	initial begin
		word_t    exp_pc;
		reg_idx_t exp_rd;
		logic     exp_wen;
		word_t    exp_wdata;
		logic     exp_st;
		word_t    exp_st_addr;
		word_t    exp_st_data;
		int       n_commit;
		clk       = 1'b0;
		rst       = 1'b1;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		pending   = 1'b0;
		first_req = 1'b1;
		delay_pos = 0;
		void'($urandom(32'h7676_cc13));
		for (int k = 0; k < DELAY_SLOTS; k++) begin
			ack_delay[k] = $urandom_range(4, 1);
		end
		build_program();
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = ref_mem[a];
		end
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		ref_pc = RESET_PC;

		// reset, 16 rising edges, outputs checked after each
		for (int k = 0; k < 16; k++) begin
			@(posedge clk);
			#2;
			if (mem_req !== 1'b0 || commit !== 1'b0) begin
				report_mismatch("mem_req or commit high during reset");
			end
		end
		rst = 1'b0;

		// every commit against the model, in order
		n_commit = 0;
		while (ref_pc != prog_end) begin
			wait_for_commit();
			ref_step(exp_pc, exp_rd, exp_wen, exp_wdata, exp_st, exp_st_addr, exp_st_data);
			check_commit(commit_pc, commit_rd, commit_wen, commit_wdata,
				exp_pc, exp_rd, exp_wen, exp_wdata);
			if (exp_st) begin
				if (wr_addr_q.size() != 1) begin
					report_problem($sformatf("sw at %h made %0d memory writes instead of one",
						exp_pc, wr_addr_q.size()));
				end
				check_store(wr_addr_q[0], wr_data_q[0], exp_st_addr, exp_st_data);
			end else if (wr_addr_q.size() != 0) begin
				report_problem($sformatf("memory write without a store, commit at %h", exp_pc));
			end
			wr_addr_q.delete();
			wr_data_q.delete();
			n_commit++;
		end
		$display("%0d instructions retired", n_commit);
		$display("Test OK");
		$finish;
	end

endmodule

// ==== core.f ====
+incdir+sim
src/rv_pkg.sv
src/mem_bus_if.sv
src/ifu.sv
src/idu.sv
src/exu.sv
src/lsu.sv
src/gpr.sv
src/mem_arbiter.sv
src/core_top.sv
sim/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_core
RTL_TOP   := core_top
FILELIST  := core.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
